// File: common/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address split into tag, index and offset
`define ICACHE_ADDR_W   32
`define ICACHE_TAG_W    20
`define ICACHE_IDX_W    8
`define ICACHE_OFFSET_W 4

// geometry
`define ICACHE_WAYS     2
`define ICACHE_SETS     256

// a line is four bus beats of one word each
`define ICACHE_BEAT_W   32
`define ICACHE_BEATS    4
`define ICACHE_LINE_W   128

`endif

// File: common/icache_pkg.sv
`include "icache_settings.svh"

`default_nettype none

package icache_pkg;

    // fetch address and its fields
    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
    typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
    typedef logic [`ICACHE_IDX_W-1:0]  idx_t;

    // bus beat and whole line with beat 0 in the low word
    typedef logic [`ICACHE_BEAT_W-1:0] beat_t;
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // way number and per-way flags
    typedef logic                      way_t;
    typedef logic [`ICACHE_WAYS-1:0]   way_vec_t;

    // counts received beats of a refill
    typedef logic [$clog2(`ICACHE_BEATS)-1:0] beat_cnt_t;

    // controller states
    typedef enum logic [1:0] {
        state_idle,
        state_lookup,
        state_request,
        state_receive
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: icache/icache_ctrl.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

`default_nettype none

module icache_ctrl (
    input  wire                   clock,
    input  wire                   reset,

    // fetch request
    input  wire                   valid_i,
    input  wire                   uncached_i,
    input  icache_pkg::addr_t     araddr_i,
    input  wire                   rd_rdy_i,

    // lookup result
    input  icache_pkg::way_vec_t  hit_i,
    input  icache_pkg::line_t     hit_line_i,

    // refill result
    input  wire                   line_ready_i,
    input  icache_pkg::line_t     refill_line_i,
    input  icache_pkg::way_t      victim_i,

    output logic                  ready_o,
    output logic                  rvalid_o,
    output icache_pkg::line_t     rdata_o,
    output logic                  rd_req_o,
    output icache_pkg::addr_t     rd_addr_o,

    // way array control
    output logic                  read_en_o,
    output icache_pkg::idx_t      read_idx_o,
    output icache_pkg::tag_t      lookup_tag_o,
    output logic                  refill_start_o,
    output logic                  fill_en_o,
    output icache_pkg::way_t      fill_way_o,
    output icache_pkg::idx_t      fill_idx_o,

    // lru update
    output logic                  touch_en_o,
    output icache_pkg::way_t      touch_way_o
);

    icache_pkg::ctrl_state_t state_q;

    // request buffer
    icache_pkg::tag_t req_tag_q;
    icache_pkg::idx_t req_idx_q;
    logic             req_uncached_q;

    logic accept;
    logic lookup_hit;
    logic receive_done;

    assign accept       = (state_q == icache_pkg::state_idle) && valid_i;
    assign lookup_hit   = (state_q == icache_pkg::state_lookup) && (|hit_i);
    assign receive_done = (state_q == icache_pkg::state_receive) && line_ready_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q        <= icache_pkg::state_idle;
            req_uncached_q <= 1'b0;
        end else begin
            case (state_q)
                icache_pkg::state_idle: begin
                    if (valid_i) begin
                        // uncached fetches skip the lookup
                        state_q <= uncached_i ? icache_pkg::state_request
                                              : icache_pkg::state_lookup;
                        req_uncached_q <= uncached_i;
                    end
                end
                icache_pkg::state_lookup: begin
                    state_q <= (|hit_i) ? icache_pkg::state_idle
                                        : icache_pkg::state_request;
                end
                icache_pkg::state_request: begin
                    if (rd_rdy_i) begin
                        state_q <= icache_pkg::state_receive;
                    end
                end
                icache_pkg::state_receive: begin
                    if (line_ready_i) begin
                        state_q <= icache_pkg::state_idle;
                    end
                end
                default: begin
                    state_q <= icache_pkg::state_idle;
                end
            endcase
        end
    end

    // address fields captured at acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            req_tag_q <= araddr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
            req_idx_q <= araddr_i[`ICACHE_OFFSET_W +: `ICACHE_IDX_W];
        end
    end

    // fetch side
    assign ready_o  = (state_q == icache_pkg::state_idle);
    assign rvalid_o = lookup_hit || receive_done;
    assign rdata_o  = lookup_hit ? hit_line_i : refill_line_i;

    // line aligned bus request
    assign rd_req_o  = (state_q == icache_pkg::state_request);
    assign rd_addr_o = {req_tag_q, req_idx_q, {`ICACHE_OFFSET_W{1'b0}}};

    // set read starts with the accepted address
    assign read_en_o    = accept;
    assign read_idx_o   = araddr_i[`ICACHE_OFFSET_W +: `ICACHE_IDX_W];
    assign lookup_tag_o = req_tag_q;

    assign refill_start_o = (state_q == icache_pkg::state_request) && rd_rdy_i;

    // fill on the final beat of cached fetches
    assign fill_en_o  = receive_done && !req_uncached_q;
    assign fill_way_o = victim_i;
    assign fill_idx_o = req_idx_q;

    // a hit or a fill makes that way the most recent one
    assign touch_en_o  = lookup_hit || fill_en_o;
    assign touch_way_o = lookup_hit ? hit_i[1] : victim_i;

endmodule

`default_nettype wire

// File: icache/icache_way_array.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

`default_nettype none

module icache_way_array (
    input  wire                   clock,
    input  wire                   reset,

    // set read at acceptance
    input  wire                   read_en_i,
    input  icache_pkg::idx_t      read_idx_i,
    input  icache_pkg::tag_t      lookup_tag_i,

    // line fill
    input  wire                   fill_en_i,
    input  icache_pkg::way_t      fill_way_i,
    input  icache_pkg::idx_t      fill_idx_i,
    input  icache_pkg::line_t     fill_line_i,

    output icache_pkg::way_vec_t  hit_o,
    output icache_pkg::line_t     hit_line_o,
    output icache_pkg::way_vec_t  valid_o
);

    // registered read of the addressed set with one entry per way
    icache_pkg::tag_t     tag_rd_q  [`ICACHE_WAYS];
    icache_pkg::line_t    line_rd_q [`ICACHE_WAYS];
    icache_pkg::way_vec_t valid_rd_q;

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_pkg::tag_t    tag_mem  [`ICACHE_SETS];
        icache_pkg::line_t   data_mem [`ICACHE_SETS];
        logic [`ICACHE_SETS-1:0] valid_q;
        logic                way_fill;

        assign way_fill = fill_en_i && (fill_way_i == icache_pkg::way_t'(w));

        always_ff @(posedge clock) begin
            if (reset) begin
                valid_q       <= '0;
                valid_rd_q[w] <= 1'b0;
            end else begin
                if (way_fill) begin
                    valid_q[fill_idx_i] <= 1'b1;
                end
                if (read_en_i) begin
                    valid_rd_q[w] <= valid_q[read_idx_i];
                end
            end
        end

        always_ff @(posedge clock) begin
            if (way_fill) begin
                tag_mem[fill_idx_i]  <= lookup_tag_i;
                data_mem[fill_idx_i] <= fill_line_i;
            end
            if (read_en_i) begin
                tag_rd_q[w]  <= tag_mem[read_idx_i];
                line_rd_q[w] <= data_mem[read_idx_i];
            end
        end

        assign hit_o[w] = valid_rd_q[w] && (tag_rd_q[w] == lookup_tag_i);
    end

    // at most one way hits and an or-mux picks its line
    always_comb begin
        hit_line_o = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_line_o = hit_line_o | ({`ICACHE_LINE_W{hit_o[w]}} & line_rd_q[w]);
        end
    end

    // still current at fill time since nothing writes between read and fill
    assign valid_o = valid_rd_q;

endmodule

`default_nettype wire

// File: icache/icache_refill.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

`default_nettype none

module icache_refill (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 start_i,
    input  wire                 ret_valid_i,
    input  icache_pkg::beat_t   ret_data_i,
    output logic                line_ready_o,
    output icache_pkg::line_t   line_o
);

    localparam icache_pkg::beat_cnt_t last_cnt = icache_pkg::beat_cnt_t'(`ICACHE_BEATS - 1);

    icache_pkg::beat_cnt_t cnt_q;
    icache_pkg::beat_t     buf_q [`ICACHE_BEATS-1];
    logic                  last_beat;

    assign last_beat = (cnt_q == last_cnt);

    always_ff @(posedge clock) begin
        if (reset) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= '0;
        end else if (ret_valid_i) begin
            // wraps to zero after the last beat
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // earlier beats wait here until the last one shows up
    always_ff @(posedge clock) begin
        if (ret_valid_i && !last_beat) begin
            buf_q[cnt_q] <= ret_data_i;
        end
    end

    assign line_ready_o = ret_valid_i && last_beat;

    // live beat goes on top
    always_comb begin
        line_o = '0;
        for (int b = 0; b < `ICACHE_BEATS - 1; b++) begin
            line_o[b*`ICACHE_BEAT_W +: `ICACHE_BEAT_W] = buf_q[b];
        end
        line_o[`ICACHE_LINE_W-1 -: `ICACHE_BEAT_W] = ret_data_i;
    end

endmodule

`default_nettype wire

// File: icache/icache_lru.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

`default_nettype none

module icache_lru (
    input  wire                   clock,
    input  wire                   reset,
    input  icache_pkg::idx_t      idx_i,
    input  icache_pkg::way_vec_t  valid_i,
    input  wire                   touch_en_i,
    input  icache_pkg::way_t      touch_way_i,
    output icache_pkg::way_t      victim_o
);

    // one bit per set naming the least recently used way
    logic [`ICACHE_SETS-1:0] lru_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            lru_q <= '0;
        end else if (touch_en_i) begin
            lru_q[idx_i] <= ~touch_way_i;
        end
    end

    // free ways first and the lowest number wins
    always_comb begin
        if (!valid_i[0]) begin
            victim_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_o = 1'b1;
        end else begin
            victim_o = lru_q[idx_i];
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_top.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

`default_nettype none

module icache_top (
    input  wire                 clock,
    input  wire                 reset,

    // fetch side
    input  wire                 valid_i,
    input  wire                 uncached_i,
    input  icache_pkg::addr_t   araddr_i,
    output logic                ready_o,
    output logic                rvalid_o,
    output icache_pkg::line_t   rdata_o,

    // bus bridge side
    output logic                rd_req_o,
    output icache_pkg::addr_t   rd_addr_o,
    input  wire                 rd_rdy_i,
    input  wire                 ret_valid_i,
    input  wire                 ret_last_i,
    input  icache_pkg::beat_t   ret_data_i
);

    icache_pkg::way_vec_t hit;
    icache_pkg::line_t    hit_line;
    icache_pkg::way_vec_t set_valid;
    logic                 line_ready;
    icache_pkg::line_t    refill_line;
    icache_pkg::way_t     victim;

    logic                 read_en;
    icache_pkg::idx_t     read_idx;
    icache_pkg::tag_t     lookup_tag;
    logic                 refill_start;
    logic                 fill_en;
    icache_pkg::way_t     fill_way;
    icache_pkg::idx_t     fill_idx;
    logic                 touch_en;
    icache_pkg::way_t     touch_way;

    icache_ctrl u_ctrl (
        .clock          (clock),
        .reset          (reset),
        .valid_i        (valid_i),
        .uncached_i     (uncached_i),
        .araddr_i       (araddr_i),
        .rd_rdy_i       (rd_rdy_i),
        .hit_i          (hit),
        .hit_line_i     (hit_line),
        .line_ready_i   (line_ready),
        .refill_line_i  (refill_line),
        .victim_i       (victim),
        .ready_o        (ready_o),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o),
        .rd_req_o       (rd_req_o),
        .rd_addr_o      (rd_addr_o),
        .read_en_o      (read_en),
        .read_idx_o     (read_idx),
        .lookup_tag_o   (lookup_tag),
        .refill_start_o (refill_start),
        .fill_en_o      (fill_en),
        .fill_way_o     (fill_way),
        .fill_idx_o     (fill_idx),
        .touch_en_o     (touch_en),
        .touch_way_o    (touch_way)
    );

    icache_way_array u_ways (
        .clock          (clock),
        .reset          (reset),
        .read_en_i      (read_en),
        .read_idx_i     (read_idx),
        .lookup_tag_i   (lookup_tag),
        .fill_en_i      (fill_en),
        .fill_way_i     (fill_way),
        .fill_idx_i     (fill_idx),
        .fill_line_i    (refill_line),
        .hit_o          (hit),
        .hit_line_o     (hit_line),
        .valid_o        (set_valid)
    );

    icache_refill u_refill (
        .clock          (clock),
        .reset          (reset),
        .start_i        (refill_start),
        .ret_valid_i    (ret_valid_i),
        .ret_data_i     (ret_data_i),
        .line_ready_o   (line_ready),
        .line_o         (refill_line)
    );

    // lru follows the set held in the request buffer
    icache_lru u_lru (
        .clock          (clock),
        .reset          (reset),
        .idx_i          (fill_idx),
        .valid_i        (set_valid),
        .touch_en_i     (touch_en),
        .touch_way_i    (touch_way),
        .victim_o       (victim)
    );

endmodule

`default_nettype wire

// File: test/icache_checker.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

`default_nettype none

module icache_checker (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 ready_i,
    input  wire                 rvalid_i,
    input  wire                 rd_req_i,
    input  icache_pkg::addr_t   rd_addr_i,
    input  wire                 rd_rdy_i,
    input  wire                 ret_valid_i,
    input  wire                 ret_last_i
);

    localparam icache_pkg::beat_cnt_t last_beat = icache_pkg::beat_cnt_t'(`ICACHE_BEATS - 1);

    // count of failed assertions
    int failures = 0;

    // beats seen since the bus took the request
    icache_pkg::beat_cnt_t beat_cnt_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            beat_cnt_q <= '0;
        end else if (rd_req_i && rd_rdy_i) begin
            beat_cnt_q <= '0;
        end else if (ret_valid_i) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    req_held: assert property (@(posedge clock) disable iff (reset)
        rd_req_i && !rd_rdy_i |=> rd_req_i && $stable(rd_addr_i))
        else begin
            failures++;
            $error("rd_req_o dropped or rd_addr_o changed before rd_rdy_i");
        end

    last_only_on_fourth: assert property (@(posedge clock) disable iff (reset)
        ret_last_i |-> ret_valid_i && (beat_cnt_q == last_beat))
        else begin
            failures++;
            $error("ret_last_i outside the fourth beat");
        end

    fourth_has_last: assert property (@(posedge clock) disable iff (reset)
        ret_valid_i && (beat_cnt_q == last_beat) |-> ret_last_i)
        else begin
            failures++;
            $error("fourth beat arrived without ret_last_i");
        end

    // responses only leave the lookup and receive states
    no_rvalid_in_idle: assert property (@(posedge clock) disable iff (reset)
        !(rvalid_i && ready_i))
        else begin
            failures++;
            $error("rvalid_o high while ready_o is high");
        end

endmodule

bind icache_top icache_checker u_checker (
    .clock       (clock),
    .reset       (reset),
    .ready_i     (ready_o),
    .rvalid_i    (rvalid_o),
    .rd_req_i    (rd_req_o),
    .rd_addr_i   (rd_addr_o),
    .rd_rdy_i    (rd_rdy_i),
    .ret_valid_i (ret_valid_i),
    .ret_last_i  (ret_last_i)
);

`default_nettype wire

// File: test/icache_tb.sv
`timescale 1ns/1ns

`default_nettype none

module icache_tb;

    localparam int clock_period     = 40;
    localparam int reset_cycles     = 16;
    localparam int directed_fetches = 11;
    localparam int random_fetches   = 200;
    // worst bus delay plus four gapped beats with margin
    localparam int max_fetch_cycles = 40;

    logic              clock;
    logic              reset;
    logic              valid_i;
    logic              uncached_i;
    icache_pkg::addr_t araddr_i;
    logic              ready_o;
    logic              rvalid_o;
    icache_pkg::line_t rdata_o;
    logic              rd_req_o;
    icache_pkg::addr_t rd_addr_o;
    logic              rd_rdy_i;
    logic              ret_valid_i;
    logic              ret_last_i;
    logic [31:0]       ret_data_i;

    int checks = 0;
    int errors = 0;
    icache_pkg::line_t expected_q [$];

    // reference tags and valid bits per way and set, one lru bit per set
    logic [19:0] model_tag   [2][256];
    bit          model_valid [2][256];
    bit          model_lru   [256];

    icache_top dut (
        .clock       (clock),
        .reset       (reset),
        .valid_i     (valid_i),
        .uncached_i  (uncached_i),
        .araddr_i    (araddr_i),
        .ready_o     (ready_o),
        .rvalid_o    (rvalid_o),
        .rdata_o     (rdata_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .rd_rdy_i    (rd_rdy_i),
        .ret_valid_i (ret_valid_i),
        .ret_last_i  (ret_last_i),
        .ret_data_i  (ret_data_i)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // memory contents as a fixed mix of line address and beat number
    function automatic logic [31:0] beat_word(icache_pkg::addr_t line_addr, int k);
        return ((line_addr ^ 32'h3c6e_f372) * 32'h9e37_79b1) + 32'h0101_0101 * (k + 1);
    endfunction

    function automatic icache_pkg::line_t expected_line(icache_pkg::addr_t addr);
        icache_pkg::line_t line;
        for (int k = 0; k < 4; k++) begin
            line[k*32 +: 32] = beat_word({addr[31:4], 4'h0}, k);
        end
        return line;
    endfunction

    // true on an expected hit; updates tags, valid bits and lru
    function automatic bit model_access(icache_pkg::addr_t addr, bit uncached);
        int idx;
        int way;
        idx = addr[11:4];
        if (uncached) begin
            return 1'b0;
        end
        for (way = 0; way < 2; way++) begin
            if (model_valid[way][idx] && model_tag[way][idx] == addr[31:12]) begin
                model_lru[idx] = (way == 0);
                return 1'b1;
            end
        end
        if (!model_valid[0][idx]) begin
            way = 0;
        end else if (!model_valid[1][idx]) begin
            way = 1;
        end else begin
            way = model_lru[idx];
        end
        model_tag[way][idx]   = addr[31:12];
        model_valid[way][idx] = 1'b1;
        model_lru[idx]        = (way == 0);
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input icache_pkg::line_t actual,
                               input icache_pkg::line_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // starts and ends 2 ns after a rising edge with the DUT idle
    task automatic fetch(input icache_pkg::addr_t addr, input bit uncached,
                         output bit went_to_bus);
        bit exp_hit;
        int cycles;
        exp_hit = model_access(addr, uncached);
        expected_q.push_back(expected_line(addr));
        went_to_bus = 1'b0;
        cycles = 0;
        valid_i = 1'b1;
        uncached_i = uncached;
        araddr_i = addr;
        @(negedge clock);
        while (!ready_o) @(negedge clock);
        @(posedge clock);
        #2;
        valid_i = 1'b0;
        do begin
            @(negedge clock);
            cycles++;
            if (rd_req_o) begin
                went_to_bus = 1'b1;
                check_value("rd_addr_o", rd_addr_o, {addr[31:4], 4'h0});
            end
        end while (!rvalid_o);
        check_value("rd_req_o seen", went_to_bus, !exp_hit);
        if (exp_hit) begin
            check_value("hit latency", cycles, 1);
        end else begin
            // a refill answers together with the fourth beat
            check_value("ret_last_i at rvalid_o", ret_valid_i && ret_last_i, 1);
        end
        @(posedge clock);
        #2;
    endtask

    // each response against the oldest expected line
    initial begin
        icache_pkg::line_t exp;
        forever begin
            @(negedge clock);
            if (!reset && rvalid_o) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("rvalid_o pulsed at %0t ns with no fetch outstanding", $time);
                end else begin
                    exp = expected_q.pop_front();
                    check_value("rdata_o", rdata_o, exp);
                end
            end
        end
    end

    // bus bridge with a random accept delay, then four beats with random gaps
    initial begin
        icache_pkg::addr_t line_addr;
        rd_rdy_i = 1'b0;
        ret_valid_i = 1'b0;
        ret_last_i = 1'b0;
        ret_data_i = '0;
        forever begin
            @(posedge clock);
            #2;
            if (!reset && rd_req_o) begin
                line_addr = rd_addr_o;
                repeat ($urandom_range(0, 3)) begin
                    @(posedge clock);
                    #2;
                end
                rd_rdy_i = 1'b1;
                @(posedge clock);
                #2;
                rd_rdy_i = 1'b0;
                for (int k = 0; k < 4; k++) begin
                    repeat ($urandom_range(0, 2)) begin
                        @(posedge clock);
                        #2;
                    end
                    ret_valid_i = 1'b1;
                    ret_data_i = beat_word(line_addr, k);
                    ret_last_i = (k == 3);
                    @(posedge clock);
                    #2;
                    ret_valid_i = 1'b0;
                    ret_last_i = 1'b0;
                end
            end
        end
    end

    initial begin
        #((reset_cycles + 4 + (directed_fetches + random_fetches) * max_fetch_cycles)
          * clock_period);
        $display("watchdog expired at %0t ns, the DUT stopped responding", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        bit bus;
        icache_pkg::addr_t a;
        icache_pkg::addr_t b;
        icache_pkg::addr_t c;
        icache_pkg::addr_t addr;
        void'($urandom(32'h0cdf_aabe));
        reset = 1'b1;
        valid_i = 1'b0;
        uncached_i = 1'b0;
        araddr_i = '0;
        repeat (reset_cycles) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        check_value("ready_o", ready_o, 1);
        check_value("rd_req_o", rd_req_o, 0);
        check_value("rvalid_o", rvalid_o, 0);
        @(posedge clock);
        #2;

        // cold miss then the same line again
        a = 32'h0000_1234;
        fetch(a, 1'b0, bus);
        check_value("cold fetch rd_req_o", bus, 1);
        fetch(a + 4, 1'b0, bus);
        check_value("refetch rd_req_o", bus, 0);

        // uncached lines never allocate
        addr = 32'h0004_5670;
        fetch(addr, 1'b1, bus);
        check_value("uncached rd_req_o", bus, 1);
        fetch(addr, 1'b1, bus);
        check_value("uncached again rd_req_o", bus, 1);
        fetch(addr, 1'b0, bus);
        check_value("cached after uncached rd_req_o", bus, 1);

        // A, B, A, C in one set evicts B
        a = 32'h0010_0a40;
        b = 32'h0020_0a48;
        c = 32'h0030_0a4c;
        fetch(a, 1'b0, bus);
        fetch(b, 1'b0, bus);
        fetch(a, 1'b0, bus);
        fetch(c, 1'b0, bus);
        fetch(a, 1'b0, bus);
        check_value("lru keeps A rd_req_o", bus, 0);
        fetch(b, 1'b0, bus);
        check_value("lru evicted B rd_req_o", bus, 1);

        // eight tags over four sets keep both ways busy
        for (int i = 0; i < random_fetches; i++) begin
            addr = ($urandom_range(0, 7) << 12) + ($urandom_range(0, 3) << 4)
                 + ($urandom_range(0, 3) << 2);
            fetch(addr, $urandom_range(0, 4) == 0, bus);
        end

        errors += dut.u_checker.failures;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/icache_pkg.sv
icache/icache_ctrl.sv
icache/icache_way_array.sv
icache/icache_refill.sv
icache/icache_lru.sv
icache/icache_top.sv
test/icache_checker.sv
test/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - common
    files:
      - common/icache_pkg.sv
      - icache/icache_ctrl.sv
      - icache/icache_way_array.sv
      - icache/icache_refill.sv
      - icache/icache_lru.sv
      - icache/icache_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/icache_checker.sv
      - test/icache_tb.sv
